/* hdl/decodePkg.sv */
`default_nettype none

package decodePkg;

    // major opcodes
    localparam logic [6:0] opcodeOpImm  = 7'b0010011;
    localparam logic [6:0] opcodeOp     = 7'b0110011;
    localparam logic [6:0] opcodeLoad   = 7'b0000011;
    localparam logic [6:0] opcodeStore  = 7'b0100011;
    localparam logic [6:0] opcodeBranch = 7'b1100011;
    localparam logic [6:0] opcodeLui    = 7'b0110111;
    localparam logic [6:0] opcodeAuipc  = 7'b0010111;
    localparam logic [6:0] opcodeJal    = 7'b1101111;
    localparam logic [6:0] opcodeJalr   = 7'b1100111;
    localparam logic [6:0] opcodeSystem = 7'b1110011;

    // alu funct3, shared by register and immediate forms
    localparam logic [2:0] funct3Add  = 3'b000;
    localparam logic [2:0] funct3Sll  = 3'b001;
    localparam logic [2:0] funct3Slt  = 3'b010;
    localparam logic [2:0] funct3Sltu = 3'b011;
    localparam logic [2:0] funct3Xor  = 3'b100;
    localparam logic [2:0] funct3Srl  = 3'b101;
    localparam logic [2:0] funct3Or   = 3'b110;
    localparam logic [2:0] funct3And  = 3'b111;

    localparam logic [2:0] funct3Lb  = 3'b000;
    localparam logic [2:0] funct3Lh  = 3'b001;
    localparam logic [2:0] funct3Lw  = 3'b010;
    localparam logic [2:0] funct3Ld  = 3'b011;
    localparam logic [2:0] funct3Lbu = 3'b100;
    localparam logic [2:0] funct3Lhu = 3'b101;
    localparam logic [2:0] funct3Lwu = 3'b110;

    localparam logic [2:0] funct3Sb = 3'b000;
    localparam logic [2:0] funct3Sh = 3'b001;
    localparam logic [2:0] funct3Sw = 3'b010;
    localparam logic [2:0] funct3Sd = 3'b011;

    localparam logic [2:0] funct3Beq  = 3'b000;
    localparam logic [2:0] funct3Bne  = 3'b001;
    localparam logic [2:0] funct3Blt  = 3'b100;
    localparam logic [2:0] funct3Bge  = 3'b101;
    localparam logic [2:0] funct3Bltu = 3'b110;
    localparam logic [2:0] funct3Bgeu = 3'b111;

    localparam logic [2:0] funct3Priv   = 3'b000;
    localparam logic [2:0] funct3Csrrw  = 3'b001;
    localparam logic [2:0] funct3Csrrs  = 3'b010;
    localparam logic [2:0] funct3Csrrc  = 3'b011;
    localparam logic [2:0] funct3Csrrwi = 3'b101;
    localparam logic [2:0] funct3Csrrsi = 3'b110;
    localparam logic [2:0] funct3Csrrci = 3'b111;

    // privileged group, told apart by funct7
    localparam logic [6:0] funct7Ecall  = 7'b0000000;
    localparam logic [6:0] funct7Mret   = 7'b0011000;
    localparam logic [6:0] funct7SysNop = 7'b0001000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instrFields_t;

    typedef enum logic [2:0] {
        clsAluReg, clsAluImm, clsLoad, clsStore, clsFlow, clsSystem, clsUnknown
    } opClass_t;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluXor, aluOr, aluAnd, aluSLess, aluULess, aluSll,
        aluSrl, aluSra, aluBranch, aluLink, aluRs1, aluCsrClear, aluUnknown
    } aluFunc_t;

    typedef enum logic [2:0] {
        srcNone, srcReg, srcImm, srcShamt, srcPcPlus4, srcPcPlusImm, srcCsr
    } aluSrc_t;

    typedef enum logic [2:0] {
        immNone, immI, immU, immB, immS, immJ, immCsr
    } immGen_t;

    typedef enum logic [2:0] {
        sizeNone, size8, size16, size32, size64
    } memSize_t;

    // s suffix means sign extended
    typedef enum logic [2:0] {
        wbNone, wb8s, wb16s, wb32s, wb64, wb8u, wb16u, wb32u
    } wbType_t;

    typedef enum logic [3:0] {
        brNone, brEq, brNe, brLtS, brLtU, brGeS, brGeU, brJal, brJalr
    } branchType_t;

    typedef enum logic [1:0] {
        useNone, useRs1, useRs1Rs2
    } regUse_t;

    typedef struct packed {
        logic        regWrite;
        aluFunc_t    aluFunc;
        aluSrc_t     aluSrc;
        immGen_t     immGen;
        logic        memRead;
        logic        memWrite;
        memSize_t    memSize;
        logic        memToReg;
        wbType_t     wbType;
        branchType_t branchType;
        logic        readCsr;
        logic        writeCsr;
        logic        isCsr;
        logic        isCsrClear;
        logic        csrFromZimm;
        logic        isEcall;
        logic        exception;
        logic        isMret;
        logic        instrMisalign;
    } control_t;

    typedef struct packed {
        control_t ctl;
        regUse_t  regUse;
    } decodeOut_t;

endpackage

`default_nettype wire

/* hdl/aluDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module aluDecoder
    import decodePkg::*;
(
    input  instrFields_t instr,
    input  opClass_t     cls,
    output decodeOut_t   result
);

    logic isImm;
    logic altFunc;

    assign isImm   = (cls == clsAluImm);
    assign altFunc = instr.funct7[5];

    always_comb begin
        result = '0;
        result.ctl.regWrite = 1'b1;
        if (isImm) begin
            result.ctl.aluSrc = srcImm;
            result.ctl.immGen = immI;
            result.regUse     = useRs1;
        end else begin
            result.ctl.aluSrc = srcReg;
            result.ctl.immGen = immNone;
            result.regUse     = useRs1Rs2;
        end

        unique case (instr.funct3)
            // addi has no sub form, bit 30 belongs to the immediate
            funct3Add:  result.ctl.aluFunc = (altFunc && !isImm) ? aluSub : aluAdd;
            funct3Xor:  result.ctl.aluFunc = aluXor;
            funct3Or:   result.ctl.aluFunc = aluOr;
            funct3And:  result.ctl.aluFunc = aluAnd;
            funct3Slt:  result.ctl.aluFunc = aluSLess;
            funct3Sltu: result.ctl.aluFunc = aluULess;
            funct3Sll:  result.ctl.aluFunc = aluSll;
            funct3Srl:  result.ctl.aluFunc = altFunc ? aluSra : aluSrl;
            default: begin
                result.ctl.aluFunc = aluUnknown;
                result.ctl.aluSrc  = srcNone;
            end
        endcase

        // immediate shifts take the shamt field
        if (isImm && (instr.funct3 == funct3Sll || instr.funct3 == funct3Srl)) begin
            result.ctl.aluSrc = srcShamt;
            result.ctl.immGen = immNone;
        end
    end

    // top only hands over the two alu classes
    aluClassCheck: assert final (cls inside {clsAluReg, clsAluImm})
        else $error("aluDecoder: unexpected class %s", cls.name());

endmodule

`default_nettype wire

/* hdl/memDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module memDecoder
    import decodePkg::*;
(
    input  instrFields_t instr,
    input  logic         isStore,
    output decodeOut_t   result
);

    always_comb begin
        result = '0;
        result.ctl.aluFunc = aluAdd;
        result.ctl.aluSrc  = srcImm;
        if (isStore) begin
            result.ctl.memWrite = 1'b1;
            result.ctl.immGen   = immS;
            result.regUse       = useRs1Rs2;
            unique case (instr.funct3)
                funct3Sb: result.ctl.memSize = size8;
                funct3Sh: result.ctl.memSize = size16;
                funct3Sw: result.ctl.memSize = size32;
                funct3Sd: result.ctl.memSize = size64;
                default:  result = '0;
            endcase
        end else begin
            result.ctl.memRead  = 1'b1;
            result.ctl.regWrite = 1'b1;
            result.ctl.memToReg = 1'b1;
            result.ctl.immGen   = immI;
            result.regUse       = useRs1;
            // size and extension of the loaded value
            unique case (instr.funct3)
                funct3Lb: begin
                    result.ctl.memSize = size8;
                    result.ctl.wbType  = wb8s;
                end
                funct3Lh: begin
                    result.ctl.memSize = size16;
                    result.ctl.wbType  = wb16s;
                end
                funct3Lw: begin
                    result.ctl.memSize = size32;
                    result.ctl.wbType  = wb32s;
                end
                funct3Ld: begin
                    result.ctl.memSize = size64;
                    result.ctl.wbType  = wb64;
                end
                funct3Lbu: begin
                    result.ctl.memSize = size8;
                    result.ctl.wbType  = wb8u;
                end
                funct3Lhu: begin
                    result.ctl.memSize = size16;
                    result.ctl.wbType  = wb16u;
                end
                funct3Lwu: begin
                    result.ctl.memSize = size32;
                    result.ctl.wbType  = wb32u;
                end
                default: result = '0;
            endcase
        end
    end

    // top raises isStore only for the store opcode
    storeOpcodeCheck: assert final (!isStore || instr.opcode == opcodeStore)
        else $error("memDecoder: store flagged for opcode %b", instr.opcode);

endmodule

`default_nettype wire

/* hdl/flowDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module flowDecoder
    import decodePkg::*;
(
    input  instrFields_t instr,
    output decodeOut_t   result
);

    always_comb begin
        result = '0;
        unique case (instr.opcode)
            opcodeBranch: begin
                result.ctl.aluFunc = aluBranch;
                result.ctl.aluSrc  = srcReg;
                result.ctl.immGen  = immB;
                result.regUse      = useRs1Rs2;
                unique case (instr.funct3)
                    funct3Beq:  result.ctl.branchType = brEq;
                    funct3Bne:  result.ctl.branchType = brNe;
                    funct3Blt:  result.ctl.branchType = brLtS;
                    funct3Bltu: result.ctl.branchType = brLtU;
                    funct3Bge:  result.ctl.branchType = brGeS;
                    funct3Bgeu: result.ctl.branchType = brGeU;
                    default:    result.ctl.branchType = brNone;
                endcase
            end
            // jumps write the link address pc + 4
            opcodeJal, opcodeJalr: begin
                result.ctl.regWrite = 1'b1;
                result.ctl.aluFunc  = aluLink;
                result.ctl.aluSrc   = srcPcPlus4;
                if (instr.opcode == opcodeJal) begin
                    result.ctl.immGen     = immJ;
                    result.ctl.branchType = brJal;
                    result.regUse         = useNone;
                end else begin
                    result.ctl.immGen     = immI;
                    result.ctl.branchType = brJalr;
                    result.regUse         = useRs1;
                end
            end
            opcodeLui, opcodeAuipc: begin
                result.ctl.regWrite = 1'b1;
                result.ctl.aluFunc  = aluLink;
                result.ctl.immGen   = immU;
                result.ctl.aluSrc   = (instr.opcode == opcodeLui) ? srcImm : srcPcPlusImm;
            end
            default: result.ctl.aluFunc = aluUnknown;
        endcase
    end

    knownInputCheck: assert final (!$isunknown({instr.opcode, instr.funct3}))
        else $error("flowDecoder: opcode or funct3 unknown");

endmodule

`default_nettype wire

/* hdl/systemDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module systemDecoder
    import decodePkg::*;
(
    input  instrFields_t instr,
    output decodeOut_t   result
);

    logic isCsrOp;
    logic zimmForm;

    // low two funct3 bits pick the csr op and bit 2 the zimm form
    assign isCsrOp  = (instr.funct3[1:0] != 2'b00);
    assign zimmForm = instr.funct3[2];

    always_comb begin
        result = '0;
        result.ctl.regWrite = 1'b1;
        result.ctl.readCsr  = 1'b1;
        result.ctl.writeCsr = 1'b1;
        result.ctl.isCsr    = 1'b1;
        result.ctl.aluSrc   = srcCsr;

        unique case (instr.funct3)
            funct3Csrrw, funct3Csrrwi: result.ctl.aluFunc = aluRs1;
            funct3Csrrs, funct3Csrrsi: result.ctl.aluFunc = aluOr;
            funct3Csrrc, funct3Csrrci: begin
                result.ctl.aluFunc    = aluCsrClear;
                result.ctl.isCsrClear = 1'b1;
            end
            funct3Priv: begin
                unique case (instr.funct7)
                    funct7Ecall: begin
                        result.ctl.aluFunc   = aluBranch;
                        result.ctl.isEcall   = 1'b1;
                        result.ctl.exception = 1'b1;
                    end
                    funct7Mret: begin
                        result.ctl.aluFunc = aluBranch;
                        result.ctl.isMret  = 1'b1;
                    end
                    funct7SysNop: result.ctl.aluFunc = aluBranch;
                    default:      result.ctl.aluFunc = aluUnknown;
                endcase
            end
            default: result.ctl.aluFunc = aluUnknown;
        endcase

        if (isCsrOp) begin
            if (zimmForm) begin
                result.ctl.immGen      = immCsr;
                result.ctl.csrFromZimm = 1'b1;
            end else begin
                result.regUse = useRs1;
            end
        end
    end

    knownInputCheck: assert final (!$isunknown({instr.funct7, instr.funct3}))
        else $error("systemDecoder: funct7 or funct3 unknown");

endmodule

`default_nettype wire

/* hdl/rv64Decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv64Decoder
    import decodePkg::*;
(
    input  logic [63:0]  pc,
    input  instrFields_t instr,
    output decodeOut_t   dec
);

    opClass_t   cls;
    opClass_t   aluCls;
    logic       isStore;
    decodeOut_t aluResult;
    decodeOut_t memResult;
    decodeOut_t flowResult;
    decodeOut_t sysResult;

    always_comb begin
        unique case (instr.opcode)
            opcodeOp:    cls = clsAluReg;
            opcodeOpImm: cls = clsAluImm;
            opcodeLoad:  cls = clsLoad;
            opcodeStore: cls = clsStore;
            opcodeBranch, opcodeJal, opcodeJalr, opcodeLui, opcodeAuipc: cls = clsFlow;
            opcodeSystem: cls = clsSystem;
            // word forms land here as well
            default:     cls = clsUnknown;
        endcase
    end

    // alu decoder only needs reg vs imm
    assign aluCls  = (cls == clsAluImm) ? clsAluImm : clsAluReg;
    assign isStore = (cls == clsStore);

    aluDecoder u_aluDecoder (
        .instr  (instr),
        .cls    (aluCls),
        .result (aluResult)
    );

    memDecoder u_memDecoder (
        .instr   (instr),
        .isStore (isStore),
        .result  (memResult)
    );

    flowDecoder u_flowDecoder (
        .instr  (instr),
        .result (flowResult)
    );

    systemDecoder u_systemDecoder (
        .instr  (instr),
        .result (sysResult)
    );

    always_comb begin
        unique case (cls)
            clsAluReg, clsAluImm: dec = aluResult;
            clsLoad, clsStore:    dec = memResult;
            clsFlow:              dec = flowResult;
            clsSystem:            dec = sysResult;
            default: begin
                dec = '0;
                dec.ctl.aluFunc = aluUnknown;
                dec.ctl.aluSrc  = srcReg;
                dec.regUse      = useNone;
            end
        endcase
        dec.ctl.instrMisalign = dec.ctl.instrMisalign | (pc[1:0] != 2'b00);
    end

    memExclusiveCheck: assert final (!(dec.ctl.memRead && dec.ctl.memWrite))
        else $error("rv64Decoder: load and store both set, opcode %b", instr.opcode);

endmodule

`default_nettype wire

/* tests/decoderTb.sv */
`timescale 1ns/1ps
`default_nettype none

module decoderTb
    import decodePkg::*;
();

    localparam int resetCycles = 4;
    // 32 alu, 16 mem, 12 flow, 11 system, 18 unknown, 32 misaligned
    localparam int vectorCount = 121;
    localparam int timeoutNs   = (resetCycles + vectorCount + 20) * 10;

    logic         clk;
    logic         rst;
    logic [63:0]  pc;
    instrFields_t instr;
    decodeOut_t   dec;

    integer seed;
    int     errorCount;
    int     checkCount;
    int     vectorsRun;

    rv64Decoder u_rv64Decoder (
        .pc    (pc),
        .instr (instr),
        .dec   (dec)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(timeoutNs);
        $display("timeout: only %0d of %0d vectors ran in time", vectorsRun, vectorCount);
        $display("sim failed");
        $finish;
    end

    function automatic instrFields_t buildWord(input logic [6:0] funct7, input logic [2:0] funct3,
                                               input logic [6:0] opcode);
        instrFields_t w;
        w.funct7 = funct7;
        w.rs2    = 5'($random(seed));
        w.rs1    = 5'($random(seed));
        w.funct3 = funct3;
        w.rd     = 5'($random(seed));
        w.opcode = opcode;
        return w;
    endfunction

    function automatic logic [63:0] randomPc(input logic misaligned);
        logic [63:0] p;
        p = {$random(seed), $random(seed)};
        p[1:0] = misaligned ? 2'(1 + $unsigned($random(seed)) % 3) : 2'b00;
        return p;
    endfunction

    function automatic logic isAssignedOpcode(input logic [6:0] op);
        return op inside {opcodeOpImm, opcodeOp, opcodeLoad, opcodeStore, opcodeBranch,
                          opcodeLui, opcodeAuipc, opcodeJal, opcodeJalr, opcodeSystem};
    endfunction

    // random word with a legal opcode, funct3 pulled back into the legal set
    function automatic instrFields_t randomLegalWord();
        logic [6:0] legalOps [10] = '{opcodeOpImm, opcodeOp, opcodeLoad, opcodeStore,
                                      opcodeBranch, opcodeLui, opcodeAuipc, opcodeJal,
                                      opcodeJalr, opcodeSystem};
        instrFields_t w;
        w = instrFields_t'($random(seed));
        w.opcode = legalOps[$unsigned($random(seed)) % 10];
        case (w.opcode)
            opcodeLoad:   if (w.funct3 == 3'b111) w.funct3 = funct3Ld;
            opcodeStore:  w.funct3[2] = 1'b0;
            opcodeBranch: if (w.funct3[2:1] == 2'b01) w.funct3[2] = 1'b1;
            opcodeSystem: begin
                if (w.funct3[1:0] == 2'b00) begin
                    w.funct3 = funct3Priv;
                    w.funct7 = funct7Mret;
                end
            end
            default: ;
        endcase
        return w;
    endfunction

    function automatic memSize_t sizeOf(input logic [1:0] code);
        case (code)
            2'd0:    return size8;
            2'd1:    return size16;
            2'd2:    return size32;
            default: return size64;
        endcase
    endfunction

    function automatic decodeOut_t expectedDecode(input instrFields_t w,
                                                  input logic [63:0] pcValue);
        decodeOut_t e;
        logic imm;
        logic alt;
        e   = '0;
        imm = (w.opcode == opcodeOpImm);
        alt = w.funct7[5];
        case (w.opcode)
            opcodeOp, opcodeOpImm: begin
                e.ctl.regWrite = 1'b1;
                e.ctl.aluSrc   = imm ? srcImm : srcReg;
                e.ctl.immGen   = imm ? immI : immNone;
                e.regUse       = imm ? useRs1 : useRs1Rs2;
                case (w.funct3)
                    funct3Add:  e.ctl.aluFunc = (alt && !imm) ? aluSub : aluAdd;
                    funct3Sll:  e.ctl.aluFunc = aluSll;
                    funct3Slt:  e.ctl.aluFunc = aluSLess;
                    funct3Sltu: e.ctl.aluFunc = aluULess;
                    funct3Xor:  e.ctl.aluFunc = aluXor;
                    funct3Srl:  e.ctl.aluFunc = alt ? aluSra : aluSrl;
                    funct3Or:   e.ctl.aluFunc = aluOr;
                    default:    e.ctl.aluFunc = aluAnd;
                endcase
                if (imm && (w.funct3 == funct3Sll || w.funct3 == funct3Srl)) begin
                    e.ctl.aluSrc = srcShamt;
                    e.ctl.immGen = immNone;
                end
            end
            opcodeLoad: begin
                if (w.funct3 != 3'b111) begin
                    e.ctl.regWrite = 1'b1;
                    e.ctl.memRead  = 1'b1;
                    e.ctl.memToReg = 1'b1;
                    e.ctl.aluFunc  = aluAdd;
                    e.ctl.aluSrc   = srcImm;
                    e.ctl.immGen   = immI;
                    e.ctl.memSize  = sizeOf(w.funct3[1:0]);
                    e.regUse       = useRs1;
                    case (w.funct3)
                        funct3Lb:  e.ctl.wbType = wb8s;
                        funct3Lh:  e.ctl.wbType = wb16s;
                        funct3Lw:  e.ctl.wbType = wb32s;
                        funct3Ld:  e.ctl.wbType = wb64;
                        funct3Lbu: e.ctl.wbType = wb8u;
                        funct3Lhu: e.ctl.wbType = wb16u;
                        default:   e.ctl.wbType = wb32u;
                    endcase
                end
            end
            opcodeStore: begin
                if (w.funct3[2] == 1'b0) begin
                    e.ctl.memWrite = 1'b1;
                    e.ctl.aluFunc  = aluAdd;
                    e.ctl.aluSrc   = srcImm;
                    e.ctl.immGen   = immS;
                    e.ctl.memSize  = sizeOf(w.funct3[1:0]);
                    e.regUse       = useRs1Rs2;
                end
            end
            opcodeBranch: begin
                e.ctl.aluFunc = aluBranch;
                e.ctl.aluSrc  = srcReg;
                e.ctl.immGen  = immB;
                e.regUse      = useRs1Rs2;
                case (w.funct3)
                    funct3Beq:  e.ctl.branchType = brEq;
                    funct3Bne:  e.ctl.branchType = brNe;
                    funct3Blt:  e.ctl.branchType = brLtS;
                    funct3Bge:  e.ctl.branchType = brGeS;
                    funct3Bltu: e.ctl.branchType = brLtU;
                    funct3Bgeu: e.ctl.branchType = brGeU;
                    default:    e.ctl.branchType = brNone;
                endcase
            end
            opcodeJal, opcodeJalr: begin
                e.ctl.regWrite   = 1'b1;
                e.ctl.aluFunc    = aluLink;
                e.ctl.aluSrc     = srcPcPlus4;
                e.ctl.immGen     = (w.opcode == opcodeJal) ? immJ : immI;
                e.ctl.branchType = (w.opcode == opcodeJal) ? brJal : brJalr;
                e.regUse         = (w.opcode == opcodeJal) ? useNone : useRs1;
            end
            opcodeLui, opcodeAuipc: begin
                e.ctl.regWrite = 1'b1;
                e.ctl.aluFunc  = aluLink;
                e.ctl.aluSrc   = (w.opcode == opcodeLui) ? srcImm : srcPcPlusImm;
                e.ctl.immGen   = immU;
            end
            opcodeSystem: begin
                // csr control bits stay set for the whole system group
                e.ctl.regWrite = 1'b1;
                e.ctl.readCsr  = 1'b1;
                e.ctl.writeCsr = 1'b1;
                e.ctl.isCsr    = 1'b1;
                e.ctl.aluSrc   = srcCsr;
                case (w.funct3)
                    funct3Csrrw, funct3Csrrwi: e.ctl.aluFunc = aluRs1;
                    funct3Csrrs, funct3Csrrsi: e.ctl.aluFunc = aluOr;
                    funct3Csrrc, funct3Csrrci: begin
                        e.ctl.aluFunc    = aluCsrClear;
                        e.ctl.isCsrClear = 1'b1;
                    end
                    funct3Priv: begin
                        if (w.funct7 == funct7Ecall) begin
                            e.ctl.aluFunc   = aluBranch;
                            e.ctl.isEcall   = 1'b1;
                            e.ctl.exception = 1'b1;
                        end else if (w.funct7 == funct7Mret) begin
                            e.ctl.aluFunc = aluBranch;
                            e.ctl.isMret  = 1'b1;
                        end else if (w.funct7 == funct7SysNop) begin
                            e.ctl.aluFunc = aluBranch;
                        end else begin
                            e.ctl.aluFunc = aluUnknown;
                        end
                    end
                    default: e.ctl.aluFunc = aluUnknown;
                endcase
                if (w.funct3 inside {funct3Csrrwi, funct3Csrrsi, funct3Csrrci}) begin
                    e.ctl.immGen      = immCsr;
                    e.ctl.csrFromZimm = 1'b1;
                end else if (w.funct3 inside {funct3Csrrw, funct3Csrrs, funct3Csrrc}) begin
                    e.regUse = useRs1;
                end
            end
            default: begin
                e.ctl.aluFunc = aluUnknown;
                e.ctl.aluSrc  = srcReg;
                e.regUse      = useNone;
            end
        endcase
        e.ctl.instrMisalign = (pcValue[1:0] != 2'b00);
        return e;
    endfunction

    task automatic checkField(input string name, input int expVal, input int actVal);
        checkCount++;
        assert (actVal == expVal)
        else begin
            errorCount++;
            $display("ERROR at %0t: %s expected %0d, actual %0d", $time, name, expVal, actVal);
        end
    endtask

    task automatic compareDecode(input decodeOut_t e);
        checkField("dec.ctl.regWrite", e.ctl.regWrite, dec.ctl.regWrite);
        checkField("dec.ctl.aluFunc", e.ctl.aluFunc, dec.ctl.aluFunc);
        checkField("dec.ctl.aluSrc", e.ctl.aluSrc, dec.ctl.aluSrc);
        checkField("dec.ctl.immGen", e.ctl.immGen, dec.ctl.immGen);
        checkField("dec.ctl.memRead", e.ctl.memRead, dec.ctl.memRead);
        checkField("dec.ctl.memWrite", e.ctl.memWrite, dec.ctl.memWrite);
        checkField("dec.ctl.memSize", e.ctl.memSize, dec.ctl.memSize);
        checkField("dec.ctl.memToReg", e.ctl.memToReg, dec.ctl.memToReg);
        checkField("dec.ctl.wbType", e.ctl.wbType, dec.ctl.wbType);
        checkField("dec.ctl.branchType", e.ctl.branchType, dec.ctl.branchType);
        checkField("dec.ctl.readCsr", e.ctl.readCsr, dec.ctl.readCsr);
        checkField("dec.ctl.writeCsr", e.ctl.writeCsr, dec.ctl.writeCsr);
        checkField("dec.ctl.isCsr", e.ctl.isCsr, dec.ctl.isCsr);
        checkField("dec.ctl.isCsrClear", e.ctl.isCsrClear, dec.ctl.isCsrClear);
        checkField("dec.ctl.csrFromZimm", e.ctl.csrFromZimm, dec.ctl.csrFromZimm);
        checkField("dec.ctl.isEcall", e.ctl.isEcall, dec.ctl.isEcall);
        checkField("dec.ctl.exception", e.ctl.exception, dec.ctl.exception);
        checkField("dec.ctl.isMret", e.ctl.isMret, dec.ctl.isMret);
        checkField("dec.ctl.instrMisalign", e.ctl.instrMisalign, dec.ctl.instrMisalign);
        checkField("dec.regUse", e.regUse, dec.regUse);
    endtask

    // drive after the rising edge, check on the falling edge
    task automatic applyVector(input instrFields_t word, input logic [63:0] pcValue);
        while (rst) @(posedge clk);
        @(posedge clk);
        #1;
        instr = word;
        pc    = pcValue;
        @(negedge clk);
        compareDecode(expectedDecode(word, pcValue));
        vectorsRun++;
    endtask

    task automatic aluSweep();
        logic [6:0] op;
        for (int form = 0; form < 2; form++) begin
            op = (form == 0) ? opcodeOp : opcodeOpImm;
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int alt = 0; alt < 2; alt++) begin
                    applyVector(buildWord({1'b0, alt[0], 5'b0}, 3'(f3), op), randomPc(1'b0));
                end
            end
        end
    endtask

    // includes the illegal load and store widths
    task automatic memAccessSweep();
        for (int f3 = 0; f3 < 8; f3++) begin
            applyVector(buildWord(7'($random(seed)), 3'(f3), opcodeLoad), randomPc(1'b0));
            applyVector(buildWord(7'($random(seed)), 3'(f3), opcodeStore), randomPc(1'b0));
        end
    endtask

    task automatic controlFlowCases();
        for (int f3 = 0; f3 < 8; f3++) begin
            applyVector(buildWord(7'($random(seed)), 3'(f3), opcodeBranch), randomPc(1'b0));
        end
        applyVector(buildWord(7'($random(seed)), 3'($random(seed)), opcodeJal), randomPc(1'b0));
        applyVector(buildWord(7'($random(seed)), 3'b000, opcodeJalr), randomPc(1'b0));
        applyVector(buildWord(7'($random(seed)), 3'($random(seed)), opcodeLui), randomPc(1'b0));
        applyVector(buildWord(7'($random(seed)), 3'($random(seed)), opcodeAuipc),
                    randomPc(1'b0));
    endtask

    task automatic systemCases();
        // funct3 4 is not a csr op
        for (int f3 = 1; f3 < 8; f3++) begin
            applyVector(buildWord(7'($random(seed)), 3'(f3), opcodeSystem), randomPc(1'b0));
        end
        applyVector(buildWord(funct7Ecall, funct3Priv, opcodeSystem), randomPc(1'b0));
        applyVector(buildWord(funct7Mret, funct3Priv, opcodeSystem), randomPc(1'b0));
        applyVector(buildWord(funct7SysNop, funct3Priv, opcodeSystem), randomPc(1'b0));
        applyVector(buildWord(7'b1111111, funct3Priv, opcodeSystem), randomPc(1'b0));
    endtask

    task automatic unknownOpcodes();
        logic [6:0] op;
        // word forms of rv64
        for (int i = 0; i < 2; i++) begin
            applyVector(buildWord(7'b0, 3'($random(seed)), 7'b0011011), randomPc(1'b0));
            applyVector(buildWord(7'b0, 3'($random(seed)), 7'b0111011), randomPc(1'b0));
        end
        for (int i = 0; i < 14; i++) begin
            op = 7'($random(seed));
            while (isAssignedOpcode(op)) begin
                op = 7'($random(seed));
            end
            applyVector(buildWord(7'($random(seed)), 3'($random(seed)), op), randomPc(1'b0));
        end
    endtask

    task automatic misalignedPcs();
        for (int i = 0; i < 32; i++) begin
            applyVector(randomLegalWord(), randomPc(1'b1));
        end
    endtask

    initial begin
        seed       = 32'haffe;
        errorCount = 0;
        checkCount = 0;
        vectorsRun = 0;
        rst        = 1'b1;
        pc         = '0;
        instr      = '0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rst = 1'b0;

        aluSweep();
        memAccessSweep();
        controlFlowCases();
        systemCases();
        unknownOpcodes();
        misalignedPcs();

        assert (vectorsRun == vectorCount)
        else begin
            errorCount++;
            $display("ran %0d vectors but %0d were planned", vectorsRun, vectorCount);
        end
        $display("vectors: %0d, checks: %0d, errors: %0d", vectorsRun, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hdl/decodePkg.sv
hdl/aluDecoder.sv
hdl/memDecoder.sv
hdl/flowDecoder.sv
hdl/systemDecoder.sv
hdl/rv64Decoder.sv
tests/decoderTb.sv

/* Bender.yml */
package:
  name: rv64_decoder

sources:
  - hdl/decodePkg.sv
  - hdl/aluDecoder.sv
  - hdl/memDecoder.sv
  - hdl/flowDecoder.sv
  - hdl/systemDecoder.sv
  - hdl/rv64Decoder.sv
  - target: simulation
    files:
      - tests/decoderTb.sv
